//--- common/arcade_pkg.sv
// Arcade cabinet shell shared definitions
// Widths, register map, keyboard codes and control types

package arcade_pkg;

	// ====================================================================
	// Widths
	// ====================================================================
	localparam int color_w     = 4;   // Game colour per channel
	localparam int vga_w       = 6;   // VGA colour per channel
	localparam int audio_w     = 10;
	localparam int audio_ext_w = 5;   // Top bits repeated below the sample
	localparam int dac_w       = 16;
	localparam int dip_w       = 5;
	localparam int joy_w       = 6;
	localparam int player_w    = 7;   // Active-low player vector
	localparam int key_w       = 8;
	localparam int addr_w      = 4;
	localparam int data_w      = 32;
	localparam int ctrl_w      = 4;   // rotate, scanlines, soft reset

	localparam logic [dip_w-1:0] dip_default = 5'd1;

	localparam int ce179_div = 14;
	localparam int ce179_w   = $clog2(ce179_div);

	// ====================================================================
	// Register map
	// ====================================================================
	localparam logic [addr_w-1:0] addr_ctrl    = 4'h0;
	localparam logic [addr_w-1:0] addr_dip     = 4'h4;
	localparam logic [addr_w-1:0] addr_id      = 4'h8;
	localparam logic [addr_w-1:0] addr_buttons = 4'hC;

	localparam logic [data_w-1:0] core_id = 32'h4341_4C50;

	localparam int ctrl_rotate     = 0;
	localparam int ctrl_soft_reset = 3;

	// Set-2 scan codes
	localparam logic [key_w-1:0] key_up     = 8'h75;
	localparam logic [key_w-1:0] key_down   = 8'h72;
	localparam logic [key_w-1:0] key_left   = 8'h6B;
	localparam logic [key_w-1:0] key_right  = 8'h74;
	localparam logic [key_w-1:0] key_coin   = 8'h76;  // ESC
	localparam logic [key_w-1:0] key_start1 = 8'h05;  // F1
	localparam logic [key_w-1:0] key_start2 = 8'h06;  // F2
	localparam logic [key_w-1:0] key_fire   = 8'h29;  // Space
	localparam logic [key_w-1:0] key_bomb   = 8'h11;  // Alt

	// Joystick bit positions
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;
	localparam int joy_bomb  = 5;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic start1;
		logic start2;
		logic coin;
	} cab_buttons_t;

	typedef enum logic [1:0] {
		off   = 2'd0,
		pct25 = 2'd1,
		pct50 = 2'd2,
		pct75 = 2'd3
	} scanline_t;

endpackage

//--- common/cfg_if.sv
// Cabinet configuration bus
// Register block drives it, control and video logic follow it
`timescale 1ns/1ns

interface cfg_if
	import arcade_pkg::*;
();

	logic             rotate;
	scanline_t        scanlines;
	logic [dip_w-1:0] dip;
	logic             core_reset;  // rst or soft reset

	modport regs (
		output rotate,
		output scanlines,
		output dip,
		output core_reset
	);

	modport user (
		input rotate,
		input scanlines,
		input dip,
		input core_reset
	);

endinterface

//--- logic/clock_enables.sv
// Clock enable generator for the game core
// 12 MHz, two-phase 6 MHz and 1.79 MHz enables from clk_sys
`timescale 1ns/1ns

module clock_enables
	import arcade_pkg::*;
(
	input  logic clk_sys,
	input  logic rst,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79
);

	localparam logic [ce179_w-1:0] ce179_reload = ce179_w'(ce179_div - 1);

	logic [1:0]         phase;
	logic [ce179_w-1:0] div179;  // Counts down to the 1.79 pulse

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			phase   <= '0;
			div179  <= ce179_reload;
			ce_12   <= 1'b0;
			ce_6p   <= 1'b0;
			ce_6n   <= 1'b0;
			ce_1p79 <= 1'b0;
		end else begin
			phase <= phase + 2'd1;

			// Both 6 MHz phases land on a 12 MHz pulse
			ce_12 <= phase[0];
			ce_6p <= phase[0] & ~phase[1];
			ce_6n <= phase[0] &  phase[1];

			if (div179 == '0) begin
				div179  <= ce179_reload;
				ce_1p79 <= 1'b1;
			end else begin
				div179  <= div179 - 1'b1;
				ce_1p79 <= 1'b0;
			end
		end
	end

endmodule

//--- controls/key_decoder.sv
// Keyboard event decoder
// Make and break events set and clear cabinet button states
`timescale 1ns/1ns

module key_decoder
	import arcade_pkg::*;
(
	input  logic             clk_sys,
	input  logic             rst,
	input  logic             key_strobe,
	input  logic             key_pressed,  // 1 on make, 0 on break
	input  logic [key_w-1:0] key_code,
	output cab_buttons_t     buttons
);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			buttons <= '0;
		end else if (key_strobe) begin
			case (key_code)
				key_up: begin
					buttons.up <= key_pressed;
				end
				key_down: begin
					buttons.down <= key_pressed;
				end
				key_left: begin
					buttons.left <= key_pressed;
				end
				key_right: begin
					buttons.right <= key_pressed;
				end
				key_fire: begin
					buttons.fire <= key_pressed;
				end
				key_bomb: begin
					buttons.bomb <= key_pressed;
				end
				key_start1: begin
					buttons.start1 <= key_pressed;
				end
				key_start2: begin
					buttons.start2 <= key_pressed;
				end
				key_coin: begin
					buttons.coin <= key_pressed;
				end
				default: begin
					// Unknown codes leave every button alone
				end
			endcase
		end
	end

endmodule

//--- controls/control_mapper.sv
// Control mapper
// Syncs both joysticks, merges them with the keys, applies the
// optional 90-degree rotation and builds active-low player vectors
`timescale 1ns/1ns

module control_mapper
	import arcade_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst,
	input  cab_buttons_t        keys,
	input  logic [joy_w-1:0]    joy_0,
	input  logic [joy_w-1:0]    joy_1,
	cfg_if.user                 cfg,
	output logic [player_w-1:0] p1_ctrl,
	output logic [player_w-1:0] p2_ctrl,
	output logic                coin_n,
	output cab_buttons_t        merged
);

	logic [joy_w-1:0] joy_0_m, joy_0_s;  // Two-stage synchronisers
	logic [joy_w-1:0] joy_1_m, joy_1_s;
	logic [joy_w-1:0] joy_any;
	logic             raw_up, raw_down, raw_left, raw_right;
	cab_buttons_t     merged_d;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			joy_0_m <= '0;
			joy_0_s <= '0;
			joy_1_m <= '0;
			joy_1_s <= '0;
		end else begin
			joy_0_m <= joy_0;
			joy_0_s <= joy_0_m;
			joy_1_m <= joy_1;
			joy_1_s <= joy_1_m;
		end
	end

	assign joy_any   = joy_0_s | joy_1_s;
	assign raw_up    = keys.up    | joy_any[joy_up];
	assign raw_down  = keys.down  | joy_any[joy_down];
	assign raw_left  = keys.left  | joy_any[joy_left];
	assign raw_right = keys.right | joy_any[joy_right];

	always_comb begin
		merged_d        = keys;
		merged_d.fire   = keys.fire | joy_any[joy_fire];
		merged_d.bomb   = keys.bomb | joy_any[joy_bomb];
		// Cabinet turned on its side
		merged_d.up     = cfg.rotate ? raw_left  : raw_up;
		merged_d.down   = cfg.rotate ? raw_right : raw_down;
		merged_d.left   = cfg.rotate ? raw_down  : raw_left;
		merged_d.right  = cfg.rotate ? raw_up    : raw_right;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			merged <= '0;
		end else begin
			merged <= merged_d;
		end
	end

	assign p1_ctrl = ~{merged.start1, merged.bomb, merged.fire, merged.left,
		merged.right, merged.up, merged.down};
	assign p2_ctrl = ~{merged.start2, merged.bomb, merged.fire, merged.left,
		merged.right, merged.up, merged.down};
	assign coin_n  = ~merged.coin;

endmodule

//--- logic/core_regs.sv
// APB register block, zero wait states
// Control, DIP switches, core ID and live button status
`timescale 1ns/1ns

module core_regs
	import arcade_pkg::*;
(
	input  logic              clk_sys,
	input  logic              rst,
	input  logic [addr_w-1:0] paddr,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [data_w-1:0] pwdata,
	output logic [data_w-1:0] prdata,
	output logic              pready,
	output logic              pslverr,
	input  cab_buttons_t      merged,
	cfg_if.regs               cfg
);

	logic [ctrl_w-1:0] ctrl_q;
	logic [dip_w-1:0]  dip_q;
	logic              access;
	logic              addr_hit;
	logic              read_only;
	logic              wr_en;

	// ====================================================================
	// Address decode
	// ====================================================================
	assign access    = psel & penable;
	assign addr_hit  = (paddr == addr_ctrl) || (paddr == addr_dip) ||
		(paddr == addr_id) || (paddr == addr_buttons);
	assign read_only = (paddr == addr_id) || (paddr == addr_buttons);

	assign pready  = 1'b1;
	assign pslverr = access & (~addr_hit | (pwrite & read_only));
	assign wr_en   = access & pwrite & ~pslverr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ctrl_q <= '0;
			dip_q  <= dip_default;
		end else if (wr_en) begin
			if (paddr == addr_ctrl) begin
				ctrl_q <= pwdata[ctrl_w-1:0];
			end
			if (paddr == addr_dip) begin
				dip_q <= pwdata[dip_w-1:0];
			end
		end
	end

	// Read mux, valid in the access phase
	always_comb begin
		prdata = '0;
		if (access) begin
			case (paddr)
				addr_ctrl:    prdata = data_w'(ctrl_q);
				addr_dip:     prdata = data_w'(dip_q);
				addr_id:      prdata = core_id;
				addr_buttons: prdata = data_w'(merged);
				default:      prdata = '0;
			endcase
		end
	end

	// ====================================================================
	// Configuration outputs
	// ====================================================================
	assign cfg.rotate     = ctrl_q[ctrl_rotate];
	assign cfg.scanlines  = scanline_t'(ctrl_q[2:1]);
	assign cfg.dip        = dip_q;
	assign cfg.core_reset = rst | ctrl_q[ctrl_soft_reset];  // Soft reset is a level

endmodule

//--- logic/video_out.sv
// VGA output stage
// Blanks and widens the game colour, dims odd lines for scanlines
// and turns the active-high game syncs into active-low VGA syncs
`timescale 1ns/1ns

module video_out
	import arcade_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst,
	input  logic [color_w-1:0] r,
	input  logic [color_w-1:0] g,
	input  logic [color_w-1:0] b,
	input  logic               hs,
	input  logic               vs,
	input  logic               hb,
	input  logic               vb,
	cfg_if.user                cfg,
	output logic [vga_w-1:0]   vga_r,
	output logic [vga_w-1:0]   vga_g,
	output logic [vga_w-1:0]   vga_b,
	output logic               vga_hs,
	output logic               vga_vs
);

	logic [vga_w-1:0] r1, g1, b1, r2, g2, b2;
	logic             hs1, vs1, hs2, vs2;
	logic             blank;
	logic             line_odd;

	function automatic logic [vga_w-1:0] dim(input logic [vga_w-1:0] v,
		input scanline_t sl);
		logic [vga_w+1:0] v3;
		v3 = {2'b00, v} + {1'b0, v, 1'b0};
		case (sl)
			pct25:   return v - (v >> 2);
			pct50:   return v - (v >> 1);
			pct75:   return v - v3[vga_w+1:2];
			default: return v;
		endcase
	endfunction

	assign blank = hb | vb;

	// ====================================================================
	// Stage 1 blank and widen
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			r1  <= '0;
			g1  <= '0;
			b1  <= '0;
			hs1 <= 1'b0;
			vs1 <= 1'b0;
		end else begin
			r1  <= blank ? '0 : {r, r[color_w-1 -: 2]};
			g1  <= blank ? '0 : {g, g[color_w-1 -: 2]};
			b1  <= blank ? '0 : {b, b[color_w-1 -: 2]};
			hs1 <= hs;
			vs1 <= vs;
		end
	end

	// Line parity, hs1 doubles as the previous hs
	always_ff @(posedge clk_sys) begin
		if (rst || vs) begin
			line_odd <= 1'b0;
		end else if (hs && !hs1) begin
			line_odd <= ~line_odd;
		end
	end

	// Stage 2 scanline dimming
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			r2  <= '0;
			g2  <= '0;
			b2  <= '0;
			hs2 <= 1'b0;
			vs2 <= 1'b0;
		end else begin
			r2  <= line_odd ? dim(r1, cfg.scanlines) : r1;
			g2  <= line_odd ? dim(g1, cfg.scanlines) : g1;
			b2  <= line_odd ? dim(b1, cfg.scanlines) : b1;
			hs2 <= hs1;
			vs2 <= vs1;
		end
	end

	// Stage 3 output register
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= r2;
			vga_g  <= g2;
			vga_b  <= b2;
			vga_hs <= ~hs2;  // Active low on the connector
			vga_vs <= ~vs2;
		end
	end

endmodule

//--- logic/audio_dac.sv
// First-order sigma-delta DAC
// Game audio to a 1-bit pulse density output
`timescale 1ns/1ns

module audio_dac
	import arcade_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst,
	input  logic [audio_w-1:0] audio,
	output logic               dac_out
);

	logic [dac_w-1:0] sample;
	logic [dac_w-1:0] acc;
	logic [dac_w:0]   sum;  // Carry out is the pulse

	// Lower 15 bits carry the sample, top bit stays clear
	assign sample = dac_w'({audio, audio[audio_w-1 -: audio_ext_w]});
	assign sum    = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[dac_w-1:0];
			dac_out <= sum[dac_w];
		end
	end

endmodule

//--- logic/cabinet_top.sv
// Arcade cabinet shell top level
// Clock enables, controls, registers, VGA and audio around the game core
`timescale 1ns/1ns

module cabinet_top
	import arcade_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst,
	// APB slave
	input  logic [addr_w-1:0]   paddr,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [data_w-1:0]   pwdata,
	output logic [data_w-1:0]   prdata,
	output logic                pready,
	output logic                pslverr,
	// Keyboard and joysticks
	input  logic                key_strobe,
	input  logic                key_pressed,
	input  logic [key_w-1:0]    key_code,
	input  logic [joy_w-1:0]    joy_0,
	input  logic [joy_w-1:0]    joy_1,
	// From the game core
	input  logic [color_w-1:0]  game_r,
	input  logic [color_w-1:0]  game_g,
	input  logic [color_w-1:0]  game_b,
	input  logic                game_hs,
	input  logic                game_vs,
	input  logic                game_hb,
	input  logic                game_vb,
	input  logic [audio_w-1:0]  game_audio,
	// To the cabinet
	output logic [vga_w-1:0]    vga_r,
	output logic [vga_w-1:0]    vga_g,
	output logic [vga_w-1:0]    vga_b,
	output logic                vga_hs,
	output logic                vga_vs,
	output logic                audio_l,
	output logic                audio_r,
	// To the game core
	output logic                ce_12,
	output logic                ce_6p,
	output logic                ce_6n,
	output logic                ce_1p79,
	output logic [player_w-1:0] p1_ctrl,
	output logic [player_w-1:0] p2_ctrl,
	output logic                coin_n,
	output logic [dip_w-1:0]    dip_sw,
	output logic                core_reset
);

	cab_buttons_t key_buttons;
	cab_buttons_t merged;

	cfg_if cfg_bus ();

	clock_enables clock_enables_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_1p79 (ce_1p79)
	);

	key_decoder key_decoder_inst (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.buttons     (key_buttons)
	);

	control_mapper control_mapper_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.keys    (key_buttons),
		.joy_0   (joy_0),
		.joy_1   (joy_1),
		.cfg     (cfg_bus),
		.p1_ctrl (p1_ctrl),
		.p2_ctrl (p2_ctrl),
		.coin_n  (coin_n),
		.merged  (merged)
	);

	core_regs core_regs_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.merged  (merged),
		.cfg     (cfg_bus)
	);

	video_out video_out_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.r       (game_r),
		.g       (game_g),
		.b       (game_b),
		.hs      (game_hs),
		.vs      (game_vs),
		.hb      (game_hb),
		.vb      (game_vb),
		.cfg     (cfg_bus),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	audio_dac audio_dac_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.audio   (game_audio),
		.dac_out (audio_l)
	);

	assign audio_r    = audio_l;  // Mono game, same stream on both sides
	assign dip_sw     = cfg_bus.dip;
	assign core_reset = cfg_bus.core_reset;

endmodule

//--- sim/cabinet_chk.sv
// Concurrent checks for the cabinet shell
// Clock enable phasing and APB slave response rules
`timescale 1ns/1ns

module cabinet_chk (
	input logic clk_sys,
	input logic rst,
	input logic ce_12,
	input logic ce_6p,
	input logic ce_6n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr
);

	// Two 6 MHz phases never overlap
	ce6_exclusive: assert property (@(posedge clk_sys) !(ce_6p && ce_6n))
		else $error("ce_6p and ce_6n high in the same cycle");

	ce6_on_ce12: assert property (@(posedge clk_sys) (ce_6p || ce_6n) |-> ce_12)
		else $error("6 MHz enable without a 12 MHz enable");

	// Zero wait state slave
	pready_high: assert property (@(posedge clk_sys) disable iff (rst) pready)
		else $error("pready dropped low");

	pslverr_access: assert property (@(posedge clk_sys) pslverr |-> (psel && penable))
		else $error("pslverr raised outside the access phase");

endmodule

//--- sim/cabinet_tb.sv
// Testbench for the arcade cabinet shell
// Drives APB, keyboard, joysticks, game video and game audio into the DUT
// and checks player vectors, registers, VGA output and the audio stream
`timescale 1ns/1ns

module cabinet_tb
	import arcade_pkg::*;
();

	localparam int clk_period   = 100;
	localparam int drive_delay  = 10;   // Inputs change this long after the edge
	localparam int access_delay = 40;   // Access phase sample point
	localparam int line_len     = 16;
	localparam int video_lines  = 6;
	localparam int video_pixels = line_len * video_lines;
	localparam int audio_cycles = 65536;
	localparam int table_len    = 40;
	localparam int row_cycles   = 10;   // Rotate write, event, status read
	localparam int test_cycles  = 16 + 56 + 40 + table_len * row_cycles +
		4 * (video_pixels + 10) + audio_cycles + 40;
	localparam int watchdog_cycles = test_cycles * 2;

	typedef struct packed {
		logic              is_joy;   // 0 key event, 1 joystick levels
		logic [key_w-1:0]  code;
		logic              pressed;
		logic [joy_w-1:0]  joy0;
		logic [joy_w-1:0]  joy1;
		logic              rotate;
		logic [player_w-1:0] p1;
		logic [player_w-1:0] p2;
		logic              coin_n;
	} ctrl_row_t;

	typedef struct packed {
		logic [vga_w-1:0] r;
		logic [vga_w-1:0] g;
		logic [vga_w-1:0] b;
		logic             hs_n;
		logic             vs_n;
	} vga_exp_t;

	logic                clk_sys;
	logic                rst;
	logic [addr_w-1:0]   paddr;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [data_w-1:0]   pwdata;
	logic [data_w-1:0]   prdata;
	logic                pready;
	logic                pslverr;
	logic                key_strobe;
	logic                key_pressed;
	logic [key_w-1:0]    key_code;
	logic [joy_w-1:0]    joy_0;
	logic [joy_w-1:0]    joy_1;
	logic [color_w-1:0]  game_r;
	logic [color_w-1:0]  game_g;
	logic [color_w-1:0]  game_b;
	logic                game_hs;
	logic                game_vs;
	logic                game_hb;
	logic                game_vb;
	logic [audio_w-1:0]  game_audio;
	logic [vga_w-1:0]    vga_r;
	logic [vga_w-1:0]    vga_g;
	logic [vga_w-1:0]    vga_b;
	logic                vga_hs;
	logic                vga_vs;
	logic                audio_l;
	logic                audio_r;
	logic                ce_12;
	logic                ce_6p;
	logic                ce_6n;
	logic                ce_1p79;
	logic [player_w-1:0] p1_ctrl;
	logic [player_w-1:0] p2_ctrl;
	logic                coin_n;
	logic [dip_w-1:0]    dip_sw;
	logic                core_reset;

	integer    seed;
	ctrl_row_t ctrl_table[$];

	cabinet_top cabinet_top_inst (.*);

	bind cabinet_top cabinet_chk cabinet_chk_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.psel    (psel),
		.penable (penable),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog timeout, the run did not finish in time");
		$display("Test failed");
		$fatal(1, "Watchdog expired");
	end

	// ====================================================================
	// Helpers
	// ====================================================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#drive_delay;
	endtask

	task automatic fail_now(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		assert (got === exp)
			else fail_now($sformatf("%s got 0x%0h, expected 0x%0h", what, got, exp));
	endtask

	task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
		input logic exp_err);
		paddr   = addr;
		pwdata  = data;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		next_cycle();
		penable = 1'b1;
		#access_delay;
		expect_value(pready, 1'b1, "pready on write");
		expect_value(pslverr, exp_err, $sformatf("pslverr on write to 0x%0h", addr));
		next_cycle();  // Write lands on this edge
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_expect(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp,
		input logic exp_err, input string what);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		next_cycle();
		penable = 1'b1;
		#access_delay;
		expect_value(pslverr, exp_err, {what, " pslverr"});
		if (!exp_err) begin
			expect_value(prdata, exp, what);
		end
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// ====================================================================
	// Control table
	// ====================================================================
	task automatic add_row(input logic is_joy, input logic [key_w-1:0] code,
		input logic pressed, input logic [joy_w-1:0] j0, input logic [joy_w-1:0] j1,
		input logic rot, input logic [6:0] p1, input logic [6:0] p2, input logic cn);
		ctrl_row_t row;
		row = '{is_joy, code, pressed, j0, j1, rot, p1, p2, cn};
		ctrl_table.push_back(row);
	endtask

	// Player vector bits 6..0 start, bomb, fire, left, right, up, down, active low
	task automatic build_ctrl_table();
		add_row(0, key_up,     1, 0, 0, 0, 7'b1111101, 7'b1111101, 1);
		add_row(0, key_up,     0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_down,   1, 0, 0, 0, 7'b1111110, 7'b1111110, 1);
		add_row(0, key_down,   0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_left,   1, 0, 0, 0, 7'b1110111, 7'b1110111, 1);
		add_row(0, key_left,   0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_right,  1, 0, 0, 0, 7'b1111011, 7'b1111011, 1);
		add_row(0, key_right,  0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_fire,   1, 0, 0, 0, 7'b1101111, 7'b1101111, 1);
		add_row(0, key_fire,   0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_bomb,   1, 0, 0, 0, 7'b1011111, 7'b1011111, 1);
		add_row(0, key_bomb,   0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_start1, 1, 0, 0, 0, 7'b0111111, 7'b1111111, 1);
		add_row(0, key_start1, 0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_start2, 1, 0, 0, 0, 7'b1111111, 7'b0111111, 1);
		add_row(0, key_start2, 0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_coin,   1, 0, 0, 0, 7'b1111111, 7'b1111111, 0);
		add_row(0, key_coin,   0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		// Unknown code while fire is held
		add_row(0, key_fire,   1, 0, 0, 0, 7'b1101111, 7'b1101111, 1);
		add_row(0, 8'h1C,      1, 0, 0, 0, 7'b1101111, 7'b1101111, 1);
		add_row(0, 8'h1C,      0, 0, 0, 0, 7'b1101111, 7'b1101111, 1);
		add_row(0, key_fire,   0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		// Rotated cabinet
		add_row(0, key_up,     1, 0, 0, 1, 7'b1111011, 7'b1111011, 1);
		add_row(0, key_up,     0, 0, 0, 1, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_down,   1, 0, 0, 1, 7'b1110111, 7'b1110111, 1);
		add_row(0, key_down,   0, 0, 0, 1, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_left,   1, 0, 0, 1, 7'b1111101, 7'b1111101, 1);
		add_row(0, key_left,   0, 0, 0, 1, 7'b1111111, 7'b1111111, 1);
		add_row(0, key_right,  1, 0, 0, 1, 7'b1111110, 7'b1111110, 1);
		add_row(0, key_right,  0, 0, 0, 1, 7'b1111111, 7'b1111111, 1);
		// Joystick rows with bit 0 right, 1 left, 2 down, 3 up, 4 fire, 5 bomb
		add_row(1, 8'h00, 0, 6'b001000, 6'b000000, 0, 7'b1111101, 7'b1111101, 1);
		add_row(0, key_down,   1, 0, 0, 0, 7'b1111100, 7'b1111100, 1);
		add_row(1, 8'h00, 0, 6'b000000, 6'b000000, 0, 7'b1111110, 7'b1111110, 1);
		add_row(0, key_down,   0, 0, 0, 0, 7'b1111111, 7'b1111111, 1);
		add_row(1, 8'h00, 0, 6'b010001, 6'b100000, 0, 7'b1001011, 7'b1001011, 1);
		add_row(1, 8'h00, 0, 6'b000000, 6'b000000, 0, 7'b1111111, 7'b1111111, 1);
		add_row(1, 8'h00, 0, 6'b000010, 6'b000000, 1, 7'b1111101, 7'b1111101, 1);
		add_row(1, 8'h00, 0, 6'b000000, 6'b000100, 1, 7'b1110111, 7'b1110111, 1);
		add_row(1, 8'h00, 0, 6'b000000, 6'b001001, 1, 7'b1111010, 7'b1111010, 1);
		add_row(1, 8'h00, 0, 6'b000000, 6'b000000, 1, 7'b1111111, 7'b1111111, 1);
	endtask

	task automatic run_control_table();
		ctrl_row_t  row;
		logic       cur_rotate;
		logic [8:0] exp_merged;
		cur_rotate = 1'b0;
		for (int i = 0; i < ctrl_table.size(); i++) begin
			row = ctrl_table[i];
			if (row.rotate !== cur_rotate) begin
				write_reg(addr_ctrl, {31'b0, row.rotate}, 1'b0);
				cur_rotate = row.rotate;
			end
			if (row.is_joy) begin
				joy_0 = row.joy0;
				joy_1 = row.joy1;
				repeat (3) next_cycle();  // Two sync stages and the output register
			end else begin
				key_strobe  = 1'b1;
				key_pressed = row.pressed;
				key_code    = row.code;
				next_cycle();
				key_strobe  = 1'b0;
				key_pressed = 1'b0;
				key_code    = '0;
				next_cycle();
			end
			expect_value(p1_ctrl, row.p1, $sformatf("row %0d p1_ctrl", i));
			expect_value(p2_ctrl, row.p2, $sformatf("row %0d p2_ctrl", i));
			expect_value(coin_n, row.coin_n, $sformatf("row %0d coin_n", i));
			// Status order up, down, left, right, fire, bomb, start1, start2, coin
			exp_merged = ~{row.p1[1], row.p1[0], row.p1[3], row.p1[2], row.p1[4],
				row.p1[5], row.p1[6], row.p2[6], row.coin_n};
			read_expect(addr_buttons, {23'b0, exp_merged}, 1'b0,
				$sformatf("row %0d buttons", i));
		end
	endtask

	// ====================================================================
	// Video and audio
	// ====================================================================
	function automatic logic [vga_w-1:0] widen(input logic [color_w-1:0] c);
		return {c, c[3:2]};
	endfunction

	function automatic logic [vga_w-1:0] scanline_level(input logic [vga_w-1:0] v,
		input int sl);
		int x;
		x = v;
		case (sl)
			1: x = x - x / 4;
			2: x = x - x / 2;
			3: x = x - (3 * x) / 4;
			default: x = v;
		endcase
		return x[vga_w-1:0];
	endfunction

	task automatic run_video(input int sl);
		vga_exp_t    exp_q[$];
		vga_exp_t    e;
		logic [31:0] rnd;
		logic        odd_line;
		logic        hs_prev;
		logic        blank;
		int          col;
		int          line;
		write_reg(addr_ctrl, 32'(sl) << 1, 1'b0);
		odd_line = 1'b0;
		hs_prev  = 1'b0;
		for (int i = 0; i < video_pixels + 3; i++) begin
			next_cycle();
			if (exp_q.size() == 3) begin
				e = exp_q.pop_front();
				expect_value(vga_r, e.r, $sformatf("scanlines %0d vga_r", sl));
				expect_value(vga_g, e.g, $sformatf("scanlines %0d vga_g", sl));
				expect_value(vga_b, e.b, $sformatf("scanlines %0d vga_b", sl));
				expect_value(vga_hs, e.hs_n, $sformatf("scanlines %0d vga_hs", sl));
				expect_value(vga_vs, e.vs_n, $sformatf("scanlines %0d vga_vs", sl));
			end
			col  = i % line_len;
			line = i / line_len;
			if (i < video_pixels) begin
				rnd     = $random(seed);
				game_r  = rnd[3:0];
				game_g  = rnd[7:4];
				game_b  = rnd[11:8];
				game_vb = (rnd[15:12] == 4'h0);
				game_hs = (col < 2);
				game_vs = (line == 0) && (col < 2);
				game_hb = (col < 4);
			end else begin
				game_hs = 1'b0;  // Idle tail while the pipeline drains
				game_vs = 1'b0;
				game_hb = 1'b1;
				game_vb = 1'b0;
			end
			// Reference model with parity updated by this pixel's syncs
			if (game_vs) begin
				odd_line = 1'b0;
			end else if (game_hs && !hs_prev) begin
				odd_line = ~odd_line;
			end
			hs_prev = game_hs;
			blank   = game_hb | game_vb;
			e.r     = blank ? '0 : widen(game_r);
			e.g     = blank ? '0 : widen(game_g);
			e.b     = blank ? '0 : widen(game_b);
			if (odd_line) begin
				e.r = scanline_level(e.r, sl);
				e.g = scanline_level(e.g, sl);
				e.b = scanline_level(e.b, sl);
			end
			e.hs_n = ~game_hs;
			e.vs_n = ~game_vs;
			exp_q.push_back(e);
		end
		exp_q.delete();
	endtask

	task automatic measure_audio(input logic [audio_w-1:0] level);
		logic [15:0] sample;
		longint      exp_ones;
		int          ones_l;
		int          ones_r;
		sample     = {1'b0, level, level[9:5]};
		game_audio = level;
		ones_l     = 0;
		ones_r     = 0;
		for (int i = 1; i <= audio_cycles; i++) begin
			next_cycle();
			ones_l += audio_l;
			ones_r += audio_r;
			// Ones expected so far from an empty accumulator
			exp_ones = (longint'(i) * sample) >> 16;
			expect_value(ones_l, exp_ones, "audio_l running count of ones");
			expect_value(ones_r, exp_ones, "audio_r running count of ones");
		end
		expect_value(ones_l, sample, "audio ones over 65536 cycles");
	endtask

	// ====================================================================
	// Reset, registers and clock enables
	// ====================================================================
	task automatic count_clock_enables();
		int n12;
		int n6p;
		int n6n;
		int n179;
		n12  = 0;
		n6p  = 0;
		n6n  = 0;
		n179 = 0;
		repeat (56) begin
			next_cycle();
			n12  += ce_12;
			n6p  += ce_6p;
			n6n  += ce_6n;
			n179 += ce_1p79;
		end
		expect_value(n12, 28, "ce_12 count");
		expect_value(n6p, 14, "ce_6p count");
		expect_value(n6n, 14, "ce_6n count");
		expect_value(n179, 4, "ce_1p79 count");
	endtask

	task automatic check_register_defaults();
		read_expect(addr_ctrl, 32'h0, 1'b0, "ctrl default");
		read_expect(addr_dip, 32'h1, 1'b0, "dip default");
		read_expect(addr_id, core_id, 1'b0, "core id");
		read_expect(4'h2, 32'h0, 1'b1, "unmapped read");
		write_reg(4'h6, 32'hFFFF_FFFF, 1'b1);
		write_reg(addr_id, 32'h1234_5678, 1'b1);
		write_reg(addr_buttons, 32'h1FF, 1'b1);
		read_expect(addr_id, core_id, 1'b0, "core id after write");
		read_expect(addr_ctrl, 32'h0, 1'b0, "ctrl after rejected writes");
	endtask

	task automatic soft_reset_and_dip();
		expect_value(core_reset, 1'b0, "core_reset before soft reset");
		write_reg(addr_ctrl, 32'h8, 1'b0);
		expect_value(core_reset, 1'b1, "core_reset after soft reset");
		read_expect(addr_ctrl, 32'h8, 1'b0, "ctrl with soft reset");
		expect_value(dip_sw, 5'h01, "dip_sw before write");
		write_reg(addr_dip, 32'h16, 1'b0);
		expect_value(dip_sw, 5'h16, "dip_sw after write");
		read_expect(addr_dip, 32'h16, 1'b0, "dip readback");
		write_reg(addr_ctrl, 32'h0, 1'b0);
		expect_value(core_reset, 1'b0, "core_reset after release");
	endtask

	// ====================================================================
	// Main sequence
	// ====================================================================
	initial begin
		seed        = 32'h1c8a6f2c;
		rst         = 1'b1;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		joy_0       = '0;
		joy_1       = '0;
		game_r      = '0;
		game_g      = '0;
		game_b      = '0;
		game_hs     = 1'b0;
		game_vs     = 1'b0;
		game_hb     = 1'b0;
		game_vb     = 1'b0;
		game_audio  = '0;
		build_ctrl_table();

		repeat (16) next_cycle();
		expect_value({ce_12, ce_6p, ce_6n, ce_1p79}, 4'h0, "enables in reset");
		expect_value(core_reset, 1'b1, "core_reset in reset");
		expect_value({vga_hs, vga_vs}, 2'b11, "syncs in reset");
		expect_value({vga_r, vga_g, vga_b}, 18'h0, "colours in reset");
		expect_value({p1_ctrl, p2_ctrl, coin_n}, 15'h7FFF, "controls in reset");
		rst = 1'b0;

		count_clock_enables();
		check_register_defaults();
		run_control_table();
		for (int sl = 0; sl < 4; sl++) begin
			run_video(sl);
		end
		measure_audio(10'h2B5);
		soft_reset_and_dip();

		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- cabinet_top.f
common/arcade_pkg.sv
common/cfg_if.sv
logic/clock_enables.sv
controls/key_decoder.sv
controls/control_mapper.sv
logic/core_regs.sv
logic/video_out.sv
logic/audio_dac.sv
logic/cabinet_top.sv
sim/cabinet_chk.sv
sim/cabinet_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cabinet shell testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module cabinet_tb -f cabinet_top.f \
	--Mdir "$build_dir" -o cabinet_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/cabinet_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Test failed" "$log_file"; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
if ! grep -q "Test completed successfully" "$log_file"; then
	echo "Simulation ended without the pass message"
	exit 1
fi

echo "Simulation passed"
exit 0
